//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;        // Data or byte address.
    typedef logic [4:0]  reg_id_t;      // Register number. Register 0 never forwards.
    typedef logic [3:0]  byte_en_t;     // Bit i covers byte i.
    typedef logic [1:0]  offset_t;      // Byte offset within a word.

    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,
        LD_BU   = 3'd2,
        LD_H    = 3'd3,
        LD_HU   = 3'd4,
        LD_W    = 3'd5,
        LD_WL   = 3'd6,
        LD_WR   = 3'd7
    } load_kind_t;

    typedef enum logic [2:0] {
        ST_NONE = 3'd0,
        ST_B    = 3'd1,
        ST_H    = 3'd2,
        ST_W    = 3'd3,
        ST_WL   = 3'd4,
        ST_WR   = 3'd5
    } store_kind_t;

    typedef enum logic {
        ACC_IDLE = 1'b0,
        ACC_WAIT = 1'b1
    } access_state_t;

    localparam int RAM_WORDS   = 64;
    localparam int RAM_ADDR_W  = 6;
    localparam int RAM_LATENCY = 2;    // Cycles from request to data_ok.
    localparam int RAM_CNT_W   = $clog2(RAM_LATENCY + 1);

endpackage

`default_nettype wire

//--- mem_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
    input  wire  Clk,
    input  wire  rst_n,
    input  wire  flush,
    input  wire  mem_op,
    input  wire  is_store,
    input  wire  data_ok,
    output logic mem_read,
    output logic mem_write,
    output logic stall
);

    mem_pkg::access_state_t state;
    mem_pkg::access_state_t state_nxt;
    logic                   issue;
    logic                   waiting;

    // A flushed instruction never reaches memory.
    assign issue   = (state == mem_pkg::ACC_IDLE) && mem_op && !flush;
    assign waiting = (state == mem_pkg::ACC_WAIT) && !data_ok && !flush;

    assign mem_read  = issue && !is_store;
    assign mem_write = issue && is_store;

    // Low in the data_ok cycle so the pipeline register captures the reply.
    assign stall = issue || waiting;

    always_comb begin
        state_nxt = state;
        case (state)
            mem_pkg::ACC_IDLE: begin
                if (issue) begin
                    state_nxt = mem_pkg::ACC_WAIT;
                end
            end
            mem_pkg::ACC_WAIT: begin
                if (data_ok || flush) begin
                    state_nxt = mem_pkg::ACC_IDLE;     // Flush abandons the access.
                end
            end
            default: begin
                state_nxt = mem_pkg::ACC_IDLE;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state <= mem_pkg::ACC_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

//--- store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  wire  mem_pkg::store_kind_t store_kind,
    input  wire  mem_pkg::offset_t     offset,
    input  wire  mem_pkg::word_t       rt_value,
    output mem_pkg::word_t             wdata,
    output mem_pkg::byte_en_t          byte_en
);

    logic [4:0] left_amt;
    logic [4:0] right_amt;

    assign left_amt  = {offset, 3'b000};       // 8*k.
    assign right_amt = {~offset, 3'b000};      // 8*(3-k).

    always_comb begin
        wdata   = rt_value;
        byte_en = 4'b0000;
        case (store_kind)
            mem_pkg::ST_B: begin
                wdata   = {4{rt_value[7:0]}};
                byte_en = 4'b0001 << offset;
            end
            mem_pkg::ST_H: begin
                wdata   = {2{rt_value[15:0]}};
                byte_en = 4'b0011 << offset;   // Offset is even.
            end
            mem_pkg::ST_W: begin
                byte_en = 4'b1111;
            end
            mem_pkg::ST_WL: begin
                // High bytes of rt land in lanes k down to 0.
                wdata   = rt_value >> right_amt;
                byte_en = 4'b1111 >> (2'd3 - offset);
            end
            mem_pkg::ST_WR: begin
                wdata   = rt_value << left_amt;
                byte_en = 4'b1111 << offset;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- load_extend.sv
`timescale 1ns/1ps
`default_nettype none

module load_extend (
    input  wire  mem_pkg::word_t      raw,
    input  wire  mem_pkg::offset_t    offset,
    input  wire  mem_pkg::load_kind_t load_kind,
    input  wire                       reg_write,
    output mem_pkg::word_t            data,
    output mem_pkg::byte_en_t         reg_byte_en
);

    mem_pkg::word_t    down;
    mem_pkg::word_t    up;
    mem_pkg::byte_en_t all_en;

    assign down   = raw >> {offset, 3'b000};      // Addressed byte moved to bit 0.
    assign up     = raw << {~offset, 3'b000};     // Addressed byte moved to bit 24.
    assign all_en = {4{reg_write}};

    always_comb begin
        data        = raw;
        reg_byte_en = all_en;
        case (load_kind)
            mem_pkg::LD_B: begin
                data = {{24{down[7]}}, down[7:0]};
            end
            mem_pkg::LD_BU: begin
                data = {24'h000000, down[7:0]};
            end
            mem_pkg::LD_H: begin
                data = {{16{down[15]}}, down[15:0]};
            end
            mem_pkg::LD_HU: begin
                data = {16'h0000, down[15:0]};
            end
            mem_pkg::LD_W: begin
                data = raw;
            end
            mem_pkg::LD_WL: begin
                // Fills register bytes 3 down to 3-k.
                data        = up;
                reg_byte_en = all_en & (4'b1111 << (2'd3 - offset));
            end
            mem_pkg::LD_WR: begin
                // Fills register bytes 3-k down to 0.
                data        = down;
                reg_byte_en = all_en & (4'b1111 >> offset);
            end
            default: begin
                data = raw;               // Non-load result.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                             Clk,
    input  wire                             rst_n,
    input  wire                             flush,
    input  wire  mem_pkg::word_t            e_pc,
    input  wire  mem_pkg::word_t            e_result,
    input  wire  mem_pkg::word_t            e_store_data,
    input  wire  mem_pkg::reg_id_t          e_rt_id,
    input  wire  mem_pkg::reg_id_t          e_reg_id,
    input  wire  mem_pkg::load_kind_t       e_load_kind,
    input  wire  mem_pkg::store_kind_t      e_store_kind,
    input  wire                             e_reg_write,
    input  wire  mem_pkg::word_t            mem_rdata,
    input  wire                             data_ok,
    output logic                            stall,
    output logic                            mem_read,
    output logic                            mem_write,
    output logic [mem_pkg::RAM_ADDR_W-1:0]  mem_addr,
    output mem_pkg::word_t                  mem_wdata,
    output mem_pkg::byte_en_t               mem_byte_en,
    output logic                            m_reg_write,
    output mem_pkg::byte_en_t               m_reg_byte_en,
    output mem_pkg::reg_id_t                m_reg_id,
    output mem_pkg::word_t                  m_data,
    output mem_pkg::word_t                  m_pc
);

    logic                 is_load;
    logic                 is_store;
    logic                 fwd_hit;
    mem_pkg::word_t       rt_value;
    mem_pkg::word_t       result_sel;
    mem_pkg::offset_t     e_offset;

    mem_pkg::word_t       m_raw;
    mem_pkg::offset_t     m_offset;
    mem_pkg::load_kind_t  m_load_kind;

    assign is_load  = (e_load_kind != mem_pkg::LD_NONE);
    assign is_store = (e_store_kind != mem_pkg::ST_NONE);
    assign e_offset = e_result[1:0];
    assign mem_addr = e_result[mem_pkg::RAM_ADDR_W+1:2];    // Word address.

    // Load followed by a store of the same register.
    assign fwd_hit  = (e_rt_id != 5'd0) && m_reg_write && (m_reg_id == e_rt_id);
    assign rt_value = fwd_hit ? m_data : e_store_data;

    assign result_sel = is_load ? mem_rdata : e_result;

    mem_access_ctrl u_ctrl (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .mem_op    (is_load || is_store),
        .is_store  (is_store),
        .data_ok   (data_ok),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .stall     (stall)
    );

    store_align u_store_align (
        .store_kind (e_store_kind),
        .offset     (e_offset),
        .rt_value   (rt_value),
        .wdata      (mem_wdata),
        .byte_en    (mem_byte_en)
    );

    always_ff @(posedge Clk) begin
        if (!rst_n || flush) begin
            m_reg_write <= 1'b0;
            m_reg_id    <= '0;
            m_load_kind <= mem_pkg::LD_NONE;
        end else if (!stall) begin
            m_reg_write <= e_reg_write;
            m_reg_id    <= e_reg_id;
            m_load_kind <= e_load_kind;
        end
    end

    // Result, offset and pc of the captured instruction.
    always_ff @(posedge Clk) begin
        if (!stall) begin
            m_raw    <= result_sel;
            m_offset <= e_offset;
            m_pc     <= e_pc;
        end
    end

    load_extend u_load_extend (
        .raw         (m_raw),
        .offset      (m_offset),
        .load_kind   (m_load_kind),
        .reg_write   (m_reg_write),
        .data        (m_data),
        .reg_byte_en (m_reg_byte_en)
    );

endmodule

`default_nettype wire

//--- data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  wire                             Clk,
    input  wire                             rst_n,
    input  wire                             mem_read,
    input  wire                             mem_write,
    input  wire  [mem_pkg::RAM_ADDR_W-1:0]  mem_addr,
    input  wire  mem_pkg::word_t            mem_wdata,
    input  wire  mem_pkg::byte_en_t         mem_byte_en,
    output mem_pkg::word_t                  mem_rdata,
    output logic                            data_ok
);

    mem_pkg::word_t                  mem [mem_pkg::RAM_WORDS];
    logic [mem_pkg::RAM_ADDR_W-1:0]  addr_q;
    logic [mem_pkg::RAM_CNT_W-1:0]   delay_cnt;
    logic                            pending;

    assign data_ok   = pending && (delay_cnt == '0);
    assign mem_rdata = mem[addr_q];     // Word as it stands now.

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_pkg::RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_byte_en[b]) begin
                    mem[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

    // A new request restarts the delay and replaces any abandoned one.
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            delay_cnt <= '0;
        end else if (mem_read || mem_write) begin
            pending   <= 1'b1;
            delay_cnt <= mem_pkg::RAM_CNT_W'(mem_pkg::RAM_LATENCY - 1);
        end else if (pending) begin
            if (delay_cnt == '0) begin
                pending <= 1'b0;        // Reply given this cycle.
            end else begin
                delay_cnt <= delay_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (mem_read || mem_write) begin
            addr_q <= mem_addr;
        end
    end

endmodule

`default_nettype wire

//--- mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  wire                         Clk,
    input  wire                         rst_n,
    input  wire                         flush,
    input  wire  mem_pkg::word_t        e_pc,
    input  wire  mem_pkg::word_t        e_result,
    input  wire  mem_pkg::word_t        e_store_data,
    input  wire  mem_pkg::reg_id_t      e_rt_id,
    input  wire  mem_pkg::load_kind_t   e_load_kind,
    input  wire  mem_pkg::store_kind_t  e_store_kind,
    input  wire                         e_reg_write,
    input  wire  mem_pkg::reg_id_t      e_reg_id,
    output logic                        stall,
    output logic                        m_reg_write,
    output mem_pkg::byte_en_t           m_reg_byte_en,
    output mem_pkg::reg_id_t            m_reg_id,
    output mem_pkg::word_t              m_data,
    output mem_pkg::word_t              m_pc
);

    logic                            mem_read;
    logic                            mem_write;
    logic [mem_pkg::RAM_ADDR_W-1:0]  mem_addr;
    mem_pkg::word_t                  mem_wdata;
    mem_pkg::byte_en_t               mem_byte_en;
    mem_pkg::word_t                  mem_rdata;
    logic                            data_ok;

    mem_stage u_mem_stage (
        .Clk           (Clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .e_pc          (e_pc),
        .e_result      (e_result),
        .e_store_data  (e_store_data),
        .e_rt_id       (e_rt_id),
        .e_reg_id      (e_reg_id),
        .e_load_kind   (e_load_kind),
        .e_store_kind  (e_store_kind),
        .e_reg_write   (e_reg_write),
        .mem_rdata     (mem_rdata),
        .data_ok       (data_ok),
        .stall         (stall),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_byte_en   (mem_byte_en),
        .m_reg_write   (m_reg_write),
        .m_reg_byte_en (m_reg_byte_en),
        .m_reg_id      (m_reg_id),
        .m_data        (m_data),
        .m_pc          (m_pc)
    );

    data_ram u_data_ram (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_rdata   (mem_rdata),
        .data_ok     (data_ok)
    );

endmodule

`default_nettype wire

//--- tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_TESTS    = 64;
    localparam int NUM_COLS     = 11;
    localparam int COL_PC       = 0;
    localparam int COL_RES      = 1;
    localparam int COL_SDATA    = 2;
    localparam int COL_RT       = 3;
    localparam int COL_LD       = 4;
    localparam int COL_ST       = 5;
    localparam int COL_RW       = 6;
    localparam int COL_RD       = 7;
    localparam int COL_EXP      = 8;
    localparam int COL_BEN      = 9;
    localparam int COL_FLUSH    = 10;

    logic                  Clk;
    logic                  rst_n;
    logic                  flush;
    mem_pkg::word_t        e_pc;
    mem_pkg::word_t        e_result;
    mem_pkg::word_t        e_store_data;
    mem_pkg::reg_id_t      e_rt_id;
    mem_pkg::load_kind_t   e_load_kind;
    mem_pkg::store_kind_t  e_store_kind;
    logic                  e_reg_write;
    mem_pkg::reg_id_t      e_reg_id;
    logic                  stall;
    logic                  m_reg_write;
    mem_pkg::byte_en_t     m_reg_byte_en;
    mem_pkg::reg_id_t      m_reg_id;
    mem_pkg::word_t        m_data;
    mem_pkg::word_t        m_pc;

    logic [31:0] tests [0:MAX_TESTS*NUM_COLS-1];   // NUM_COLS words per test line.
    int          n_tests;
    int          error_count;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    mem_subsystem DUT (
        .Clk           (Clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .e_pc          (e_pc),
        .e_result      (e_result),
        .e_store_data  (e_store_data),
        .e_rt_id       (e_rt_id),
        .e_load_kind   (e_load_kind),
        .e_store_kind  (e_store_kind),
        .e_reg_write   (e_reg_write),
        .e_reg_id      (e_reg_id),
        .stall         (stall),
        .m_reg_write   (m_reg_write),
        .m_reg_byte_en (m_reg_byte_en),
        .m_reg_id      (m_reg_id),
        .m_data        (m_data),
        .m_pc          (m_pc)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT kept stalling", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] field(input int i, input int c);
        return tests[i * NUM_COLS + c];
    endfunction

    task automatic check_value(input string name, input string where,
                               input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s at %s: got 0x%h, expected 0x%h", name, where, got, exp);
        end
    endtask

    task automatic drive_line(input int i);
        logic [31:0] rt;
        logic [31:0] ld;
        logic [31:0] st;
        logic [31:0] rw;
        logic [31:0] rd;
        rt = field(i, COL_RT);
        ld = field(i, COL_LD);
        st = field(i, COL_ST);
        rw = field(i, COL_RW);
        rd = field(i, COL_RD);
        e_pc         <= field(i, COL_PC);
        e_result     <= field(i, COL_RES);
        e_store_data <= field(i, COL_SDATA);
        e_rt_id      <= rt[4:0];
        e_load_kind  <= mem_pkg::load_kind_t'(ld[2:0]);
        e_store_kind <= mem_pkg::store_kind_t'(st[2:0]);
        e_reg_write  <= rw[0];
        e_reg_id     <= rd[4:0];
    endtask

    task automatic drive_bubble();
        e_pc         <= '0;
        e_result     <= '0;
        e_store_data <= '0;
        e_rt_id      <= '0;
        e_load_kind  <= mem_pkg::LD_NONE;
        e_store_kind <= mem_pkg::ST_NONE;
        e_reg_write  <= 1'b0;
        e_reg_id     <= '0;
    endtask

    task automatic check_outputs(input int i, input string where);
        if (field(i, COL_FLUSH) != 0) begin
            check_value("m_reg_write", where, m_reg_write, 32'd0);
        end else begin
            check_value("m_reg_write", where, m_reg_write, field(i, COL_RW) & 32'd1);
            check_value("m_reg_id", where, m_reg_id, field(i, COL_RD));
            check_value("m_pc", where, m_pc, field(i, COL_PC));
            check_value("m_data", where, m_data, field(i, COL_EXP));
        end
        check_value("m_reg_byte_en", where, m_reg_byte_en, field(i, COL_BEN));
    endtask

    initial begin
        int    stall_cycles;
        int    expected_stall;
        string where;
        rst_n        = 1'b0;
        flush        = 1'b0;
        e_pc         = '0;
        e_result     = '0;
        e_store_data = '0;
        e_rt_id      = '0;
        e_load_kind  = mem_pkg::LD_NONE;
        e_store_kind = mem_pkg::ST_NONE;
        e_reg_write  = 1'b0;
        e_reg_id     = '0;
        error_count  = 0;
        n_tests      = 0;

        $readmemh("mem_tests.txt", tests);
        while (n_tests < MAX_TESTS && tests[n_tests * NUM_COLS] !== 32'hxxxxxxxx) begin
            n_tests++;
        end
        cycle_limit = n_tests * (mem_pkg::RAM_LATENCY + 4) + RESET_CYCLES;
        if (n_tests == 0) begin
            $display("No test lines could be read from mem_tests.txt");
            error_count++;
        end

        repeat (RESET_CYCLES) @(posedge Clk);
        rst_n <= 1'b1;
        @(negedge Clk);
        check_value("m_reg_write", "reset", m_reg_write, 32'd0);
        check_value("m_reg_byte_en", "reset", m_reg_byte_en, 32'd0);
        check_value("stall", "reset", stall, 32'd0);

        @(posedge Clk);
        if (n_tests > 0) begin
            drive_line(0);
        end
        @(negedge Clk);
        for (int i = 0; i < n_tests; i++) begin
            where = $sformatf("test %0d", i);
            if (field(i, COL_FLUSH) != 0) begin
                // Flush lands in the cycle the load waits on memory.
                check_value("stall", where, stall, 32'd1);
                @(posedge Clk);
                flush <= 1'b1;
                @(posedge Clk);
                flush <= 1'b0;
            end else begin
                stall_cycles = 0;
                while (stall) begin
                    stall_cycles++;
                    @(negedge Clk);
                end
                expected_stall = (field(i, COL_LD) != 0 || field(i, COL_ST) != 0) ?
                                 mem_pkg::RAM_LATENCY : 0;
                check_value("stall cycles", where, stall_cycles, expected_stall);
                @(posedge Clk);                // Capturing edge.
            end
            if (i + 1 < n_tests) begin
                drive_line(i + 1);
            end else begin
                drive_bubble();
            end
            @(negedge Clk);
            check_outputs(i, where);
        end

        $display("%0d test lines run, %0d errors", n_tests, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_tests.txt
// pc result store_data rt load_kind store_kind reg_write reg_id exp_data exp_byte_en flush
// load_kind 1 lb 2 lbu 3 lh 4 lhu 5 lw 6 lwl 7 lwr, store_kind 1 sb 2 sh 3 sw 4 swl 5 swr
00400000 00000000 00000000 00 0 0 0 00 00000000 0 0
00400004 12345678 00000000 00 0 0 1 05 12345678 f 0
00400008 cafef00d 00000000 00 0 0 1 1f cafef00d f 0
// Word store, then loads of each width from it
0040000c 00000010 a1b2c3d4 00 0 3 0 00 00000010 0 0
00400010 00000010 00000000 00 5 0 1 02 a1b2c3d4 f 0
00400014 00000011 00000000 00 1 0 1 03 ffffffc3 f 0
00400018 00000011 00000000 00 2 0 1 04 000000c3 f 0
0040001c 00000012 00000000 00 3 0 1 05 ffffa1b2 f 0
00400020 00000010 00000000 00 4 0 1 06 0000c3d4 f 0
// sb at offsets 0 to 3 and sh at offsets 0 and 2
00400024 00000020 00000011 00 0 1 0 00 00000020 0 0
00400028 00000021 ffffff22 00 0 1 0 00 00000021 0 0
0040002c 00000022 12345633 00 0 1 0 00 00000022 0 0
00400030 00000023 00000044 00 0 1 0 00 00000023 0 0
00400034 00000020 00000000 00 5 0 1 07 44332211 f 0
00400038 00000024 0000beef 00 0 2 0 00 00000024 0 0
0040003c 00000026 12347f01 00 0 2 0 00 00000026 0 0
00400040 00000024 00000000 00 3 0 1 08 ffffbeef f 0
00400044 00000026 00000000 00 3 0 1 0a 00007f01 f 0
// swl and swr in pairs that fill one word each
0040004c 00000061 11223344 00 0 4 0 00 00000061 0 0
00400050 00000062 55667788 00 0 5 0 00 00000062 0 0
00400054 00000060 00000000 00 5 0 1 0b 77881122 f 0
00400058 00000064 11223344 00 0 4 0 00 00000064 0 0
0040005c 00000065 55667788 00 0 5 0 00 00000065 0 0
00400060 00000064 00000000 00 5 0 1 0c 66778811 f 0
00400064 0000006a 11223344 00 0 4 0 00 0000006a 0 0
00400068 0000006b 55667788 00 0 5 0 00 0000006b 0 0
0040006c 00000068 00000000 00 5 0 1 0d 88112233 f 0
00400070 0000006f 11223344 00 0 4 0 00 0000006f 0 0
00400074 0000006c 00000000 00 5 0 1 0e 11223344 f 0
00400078 00000070 55667788 00 0 5 0 00 00000070 0 0
0040007c 00000070 00000000 00 5 0 1 0f 55667788 f 0
// lwl and lwr at offsets 0 to 3 of word a1b2c3d4
00400080 00000010 00000000 00 6 0 1 10 d4000000 8 0
00400084 00000011 00000000 00 6 0 1 11 c3d40000 c 0
00400088 00000012 00000000 00 6 0 1 12 b2c3d400 e 0
0040008c 00000013 00000000 00 6 0 1 13 a1b2c3d4 f 0
00400090 00000010 00000000 00 7 0 1 14 a1b2c3d4 f 0
00400094 00000011 00000000 00 7 0 1 15 00a1b2c3 7 0
00400098 00000012 00000000 00 7 0 1 16 0000a1b2 3 0
0040009c 00000013 00000000 00 7 0 1 17 000000a1 1 0
// Load into r7, store of r7 with stale data, read back; then a flushed load
004000a0 00000020 00000000 00 5 0 1 07 44332211 f 0
004000a4 00000050 deadbeef 07 0 3 0 00 00000050 0 0
004000a8 00000050 00000000 00 5 0 1 18 44332211 f 0
004000ac 00000010 00000000 00 5 0 1 19 00000000 0 1
004000b0 00000000 00000000 00 0 0 0 00 00000000 0 0

//--- src.f
mem_pkg.sv
mem_access_ctrl.sv
store_align.sv
load_extend.sv
mem_stage.sv
data_ram.sv
mem_subsystem.sv
tb_mem_subsystem.sv
